//--- program.hex
// one 32-bit instruction word per line, word 0 at pc 0
8c010000  // lw   $1, 0($0)
8c020004  // lw   $2, 4($0)
8c030008  // lw   $3, 8($0)
8c04000c  // lw   $4, 12($0)
8e650028  // lw   $5, 40($19), $19 is 0 right after reset
00233020  // add  $6, $1, $3
00233822  // sub  $7, $1, $3, goes negative
00834024  // and  $8, $4, $3
00224825  // or   $9, $1, $2
00825026  // xor  $10, $4, $2
00235827  // nor  $11, $1, $3
0041602a  // slt  $12, $2, $1, negative vs positive
0022682a  // slt  $13, $1, $2
00047100  // sll  $14, $4, 4
00027a02  // srl  $15, $2, 8
2030fffd  // addi $16, $1, -3
3091ff0f  // andi $17, $4, 0xff0f
34328000  // ori  $18, $1, 0x8000
ac0a0028  // sw   $10, 40($0)
8c130028  // lw   $19, 40($0)
026aa022  // sub  $20, $19, $10
2275ffff  // addi $21, $19, -1
00230020  // add  $0, $1, $3

//--- data.hex
// one 32-bit data word per line, word 0 at byte address 0
00000007
fffffff0
0000000c
12345678
0000abcd
80000000
00000055
000000aa
11111111
22222222
0badf00d
33333333
44444444
55555555
66666666

//--- flist.f
isaPkg.sv
corePkg.sv
instrFetch.sv
mainControl.sv
registerFile.sv
alu.sv
dataMemory.sv
mipsCore.sv
mipsCore_assertions.sv
mipsCore_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and pass only if the log holds the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module mipsCore_tb -f flist.f -o simv
obj_dir/simv | tee sim.log
grep -qx "TESTS PASSED" sim.log
echo "simulation log shows a pass"

//--- mipsCore_tb.sv
module mipsCore_tb
  import isaPkg::*, corePkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PROG_LEN       = 23;   // words in program.hex
  localparam int TIMEOUT_CYCLES = 100;  // about 45 used: reset, program, idle, re-run

  logic     clk = 1'b0;
  logic     reset;
  pc_t      pc;
  logic     regWriteEn, memWriteEn;
  regAddr_t regWriteAddr;
  word_t    regWriteData, memAddr, memWriteData;

  // --------------------
  // reference model state
  word_t progMem   [IMEM_WORDS];
  word_t modelMem  [DMEM_WORDS];  // not touched by reset
  word_t modelRegs [REG_COUNT];
  pc_t   modelPc;

  // predicted effect of the current instruction
  logic     expRegEn, expMemEn;
  regAddr_t expRegAddr;
  word_t    expRegData, expMemAddr, expMemData;

  int     errors, checks, cycleCount;
  integer seed;

  mipsCore dut0 (
    .clk(clk), .reset(reset), .pc(pc), .regWriteEn(regWriteEn),
    .regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
    .memWriteEn(memWriteEn), .memAddr(memAddr), .memWriteData(memWriteData)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------
  // compare tasks
  task automatic checkWord(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkAddr(input string name, input regAddr_t exp, input regAddr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic checkPc(input string name, input pc_t exp, input pc_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // --------------------
  // reference model
  task automatic predict(input word_t instr);
    word_t a, b, imm32, result;
    a          = modelRegs[instr[25:21]];  // rs
    b          = modelRegs[instr[20:16]];  // rt
    imm32      = {{16{instr[15]}}, instr[15:0]};  // andi / ori sign-extend too
    expMemAddr = a + imm32;
    expMemData = b;
    result     = expMemAddr;  // addi
    expRegAddr = instr[20:16];
    expRegEn   = 1'b1;
    expMemEn   = 1'b0;
    case (opcode_t'(instr[31:26]))
      OP_RTYPE: begin
        expRegAddr = instr[15:11];  // rd
        case (funct_t'(instr[5:0]))
          FN_SUB:  result = a - b;
          FN_AND:  result = a & b;
          FN_OR:   result = a | b;
          FN_XOR:  result = a ^ b;
          FN_NOR:  result = ~(a | b);
          FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FN_SLL:  result = b << instr[10:6];
          FN_SRL:  result = b >> instr[10:6];
          default: result = a + b;  // add, unknown funct too
        endcase
      end
      OP_LW:   result = modelMem[expMemAddr[6:2]];  // word index mod 32
      OP_SW: begin
        expRegEn = 1'b0;
        expMemEn = 1'b1;
      end
      OP_ANDI: result = a & imm32;
      OP_ORI:  result = a | imm32;
      OP_ADDI: ;
      default: expRegEn = 1'b0;  // unknown opcode, no-op
    endcase
    expRegData = result;
    if (expRegAddr == '0) expRegEn = 1'b0;
  endtask

  // check mid-cycle, retire in the model, then move to the next edge
  task automatic runInstr(input string name);
    predict(progMem[modelPc[6:2]]);
    @(negedge clk);
    checkPc({name, " pc"}, modelPc, pc);
    checkBit({name, " regWriteEn"}, expRegEn, regWriteEn);
    checkBit({name, " memWriteEn"}, expMemEn, memWriteEn);
    if (expRegEn) begin
      checkAddr({name, " regWriteAddr"}, expRegAddr, regWriteAddr);
      checkWord({name, " regWriteData"}, expRegData, regWriteData);
    end
    if (expMemEn) begin
      checkWord({name, " memAddr"}, expMemAddr, memAddr);
      checkWord({name, " memWriteData"}, expMemData, memWriteData);
    end
    if (expRegEn) modelRegs[expRegAddr] = expRegData;
    if (expMemEn) modelMem[expMemAddr[6:2]] = expMemData;
    modelPc = modelPc + PC_STEP;
    @(posedge clk);
  endtask

  task automatic applyReset(input string name, input int cycles);
    @(posedge clk);
    reset <= 1'b1;
    repeat (cycles) begin
      @(negedge clk);
      checkPc({name, " pc"}, RESET_PC, pc);
      checkBit({name, " regWriteEn"}, 1'b0, regWriteEn);
      checkBit({name, " memWriteEn"}, 1'b0, memWriteEn);
    end
    @(posedge clk);
    reset <= 1'b0;  // cycle 0 starts here
    modelPc = RESET_PC;
    foreach (modelRegs[i]) modelRegs[i] = '0;
  endtask

  // --------------------
  // directed tests, in program order
  task automatic testLoads();
    repeat (5) runInstr("loads");
  endtask

  task automatic testRegOps();
    repeat (10) runInstr("register ops");
  endtask

  task automatic testImmediates();
    repeat (3) runInstr("immediates");
  endtask

  // sw, load back, two uses of it, add into $0
  task automatic testStore();
    repeat (PROG_LEN - 18) runInstr("store");
  endtask

  task automatic testMidReset();
    int idle;
    idle = 1 + ($unsigned($random(seed)) % 6);  // stays inside the rom tail
    repeat (idle) @(posedge clk);
    applyReset("mid reset", 3);
    repeat (6) runInstr("mid reset rerun");  // word 4 loads the stored word via $19
  endtask

  initial begin
    reset = 1'b1;
    seed  = 32'hfcc2_f1d8;
    $readmemh("program.hex", progMem);
    $readmemh("data.hex", modelMem);
    applyReset("reset", 5);
    testLoads();
    testRegOps();
    testImmediates();
    testStore();
    testMidReset();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- mipsCore_assertions.sv
module mipsCore_assertions
  import isaPkg::*, corePkg::*;
(
  input logic     clk,
  input logic     reset,
  input pc_t      pc,
  input logic     regWriteEn,
  input regAddr_t regWriteAddr,
  input logic     memWriteEn
);

  timeunit 1ns;
  timeprecision 100ps;

  // an instruction writes a register or memory, never both
  writesExclusive: assert property (
    @(posedge clk) disable iff (reset) !(regWriteEn && memWriteEn)
  ) else $error("register write and memory write enabled in the same cycle");

  noWriteToZero: assert property (
    @(posedge clk) disable iff (reset) regWriteEn |-> regWriteAddr != '0  // $0 stays 0
  ) else $error("register write enabled with register 0 as destination");

  // one word per cycle, no stalls
  pcSteps: assert property (
    @(posedge clk) disable iff (reset) !$past(reset) |-> pc == $past(pc) + PC_STEP
  ) else $error("pc did not advance by one word");

endmodule

bind mipsCore mipsCore_assertions assert0 (
  .clk(clk), .reset(reset), .pc(pc), .regWriteEn(regWriteEn),
  .regWriteAddr(regWriteAddr), .memWriteEn(memWriteEn)
);

//--- mipsCore.sv
module mipsCore
  import isaPkg::*, corePkg::*;
(
  input  logic     clk,
  input  logic     reset,
  output pc_t      pc,
  output logic     regWriteEn,
  output regAddr_t regWriteAddr,
  output word_t    regWriteData,
  output logic     memWriteEn,
  output word_t    memAddr,
  output word_t    memWriteData
);

  // instruction fields
  opcode_t  opcode;
  regAddr_t rs, rt, rd;
  shamt_t   shamt;
  funct_t   funct;
  imm_t     imm;

  // control
  logic   regDst, aluSrc, memToReg, memRead, memWrite, regWrite;
  aluOp_t aluOp;

  // datapath
  word_t    rsData, rtData;
  word_t    signImm;     // imm sign-extended, also for andi / ori
  word_t    aluB;
  word_t    aluResult;
  word_t    readData;
  word_t    writeBack;
  regAddr_t destAddr;

  // --------------------
  // fetch and decode
  // --------------------
  instrFetch fetch0 (
    .clk(clk), .reset(reset), .pc(pc),
    .opcode(opcode), .rs(rs), .rt(rt), .rd(rd),
    .shamt(shamt), .funct(funct), .imm(imm)
  );

  mainControl ctrl0 (
    .opcode(opcode), .funct(funct),
    .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg),
    .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite),
    .aluOp(aluOp)
  );

  // --------------------
  // execute
  // --------------------
  assign signImm  = {{16{imm[15]}}, imm};
  assign aluB     = aluSrc ? signImm : rtData;
  assign destAddr = regDst ? rd : rt;

  registerFile regs0 (
    .clk(clk), .reset(reset), .rs(rs), .rt(rt),
    .writeAddr(destAddr), .writeEn(regWriteEn), .writeData(writeBack),
    .rsData(rsData), .rtData(rtData)
  );

  alu alu0 (
    .a(rsData), .b(aluB), .shamt(shamt), .aluOp(aluOp), .result(aluResult)
  );

  dataMemory dmem0 (
    .clk(clk), .addr(aluResult), .writeData(rtData),
    .readEn(memRead), .writeEn(memWriteEn), .readData(readData)
  );

  assign writeBack = memToReg ? readData : aluResult;

  // --------------------
  // retired effect
  // --------------------
  // nothing retires while reset is held, data memory has no reset of its own
  assign regWriteEn   = regWrite && (destAddr != '0) && !reset;  // $0 stays 0
  assign memWriteEn   = memWrite && !reset;
  assign regWriteAddr = destAddr;
  assign regWriteData = writeBack;
  assign memAddr      = aluResult;
  assign memWriteData = rtData;

endmodule

//--- dataMemory.sv
module dataMemory
  import isaPkg::*, corePkg::*;
(
  input  logic  clk,
  input  word_t addr,       // byte address from the alu
  input  word_t writeData,
  input  logic  readEn,
  input  logic  writeEn,
  output word_t readData
);

  word_t     mem [DMEM_WORDS];
  memIndex_t wordIdx;

  // preloaded once, survives core reset
  initial begin
    $readmemh("data.hex", mem);
  end

  // low address bits dropped, upper bits wrap
  assign wordIdx = memIndex_t'((addr / WORD_BYTES) % DMEM_WORDS);

  // --------------------
  // write, one edge
  // --------------------
  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[wordIdx] <= writeData;
    end
  end

  // async read, quiet unless a load is in flight
  assign readData = readEn ? mem[wordIdx] : '0;

endmodule

//--- alu.sv
module alu
  import isaPkg::*, corePkg::*;
(
  input  word_t  a,      // rsData
  input  word_t  b,      // rtData or immediate
  input  shamt_t shamt,
  input  aluOp_t aluOp,
  output word_t  result
);

  logic lessThan;  // signed a < b

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (aluOp)
      // arithmetic, wraps mod 2^32, no flags
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;

      // --------------------
      // bitwise
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_NOR: result = ~(a | b);

      // set on less than, 1 or 0
      ALU_SLT: result = {31'd0, lessThan};

      // --------------------
      // shifts
      // source is b (rt), as in mips
      ALU_SLL: result = b << shamt;
      ALU_SRL: result = b >> shamt;  // zero fill

      default: result = '0;
    endcase
  end

endmodule

//--- registerFile.sv
module registerFile
  import isaPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  regAddr_t rs,
  input  regAddr_t rt,
  input  regAddr_t writeAddr,
  input  logic     writeEn,
  input  word_t    writeData,
  output word_t    rsData,
  output word_t    rtData
);

  word_t regs [REG_COUNT];

  // --------------------
  // write port
  // --------------------
  // the decode starts at 1, so register 0 keeps its reset value of 0
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < REG_COUNT; i++) begin
        if (writeEn && writeAddr == regAddr_t'(i)) begin
          regs[i] <= writeData;
        end
      end
    end
  end

  // --------------------
  // read ports
  // --------------------
  // async, so a read of the register being written sees the old value
  assign rsData = regs[rs];
  assign rtData = regs[rt];

endmodule

//--- mainControl.sv
module mainControl
  import isaPkg::*, corePkg::*;
(
  input  opcode_t opcode,
  input  funct_t  funct,
  output logic    regDst,    // 1: rd, 0: rt
  output logic    aluSrc,    // 1: sign-extended imm, 0: rtData
  output logic    memToReg,  // 1: load data, 0: alu result
  output logic    memRead,
  output logic    memWrite,
  output logic    regWrite,
  output aluOp_t  aluOp
);

  aluClass_t aluClass;  // coarse request, refined by funct below

  // --------------------
  // opcode decode
  // --------------------
  always_comb begin
    // anything unknown falls through as a no-op
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    regWrite = 1'b0;
    aluClass = ADD_CLASS;
    case (opcode)
      OP_RTYPE: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        aluClass = RTYPE_CLASS;
      end
      OP_LW: begin
        aluSrc   = 1'b1;  // base + offset
        memToReg = 1'b1;
        memRead  = 1'b1;
        regWrite = 1'b1;
      end
      OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;  // no register write
      end
      OP_ADDI: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
      end
      OP_ANDI: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        aluClass = AND_CLASS;
      end
      OP_ORI: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        aluClass = OR_CLASS;
      end
      default: ;
    endcase
  end

  // --------------------
  // alu operation
  // --------------------
  always_comb begin
    case (aluClass)
      AND_CLASS: aluOp = ALU_AND;
      OR_CLASS:  aluOp = ALU_OR;
      RTYPE_CLASS: begin
        case (funct)
          FN_ADD:  aluOp = ALU_ADD;
          FN_SUB:  aluOp = ALU_SUB;
          FN_AND:  aluOp = ALU_AND;
          FN_OR:   aluOp = ALU_OR;
          FN_XOR:  aluOp = ALU_XOR;
          FN_NOR:  aluOp = ALU_NOR;
          FN_SLT:  aluOp = ALU_SLT;
          FN_SLL:  aluOp = ALU_SLL;
          FN_SRL:  aluOp = ALU_SRL;
          default: aluOp = ALU_ADD;  // unknown funct acts as add
        endcase
      end
      default: aluOp = ALU_ADD;  // address and addi
    endcase
  end

endmodule

//--- instrFetch.sv
module instrFetch
  import isaPkg::*, corePkg::*;
(
  input  logic     clk,
  input  logic     reset,
  output pc_t      pc,
  output opcode_t  opcode,
  output regAddr_t rs,
  output regAddr_t rt,
  output regAddr_t rd,
  output shamt_t   shamt,
  output funct_t   funct,
  output imm_t     imm
);

  word_t     rom [IMEM_WORDS];  // program store, read only
  word_t     instr;             // word at the current pc
  memIndex_t fetchIdx;

  // contents come from the program image at time zero
  initial begin
    $readmemh("program.hex", rom);
  end

  // --------------------
  // program counter
  // --------------------
  // straight-line code only, so pc just steps every edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc + PC_STEP;
    end
  end

  // word index, wraps at the rom depth
  assign fetchIdx = memIndex_t'(pc / WORD_BYTES);
  assign instr    = rom[fetchIdx];  // async read, same cycle

  // --------------------
  // field split
  // --------------------
  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];  // r-type only
  assign shamt  = instr[10:6];   // r-type only
  assign funct  = instr[5:0];    // r-type only
  assign imm    = instr[15:0];   // overlaps rd / shamt / funct

endmodule

//--- corePkg.sv
package corePkg;

  // --------------------
  // addresses and memories
  // --------------------
  typedef logic [31:0] pc_t;  // byte address

  localparam int IMEM_WORDS = 32;
  localparam int DMEM_WORDS = 32;

  // index width covers the deeper of the two memories
  localparam int MEM_INDEX_BITS = $clog2(IMEM_WORDS > DMEM_WORDS ? IMEM_WORDS : DMEM_WORDS);
  typedef logic [MEM_INDEX_BITS-1:0] memIndex_t;

  localparam pc_t PC_STEP  = 32'd4;  // one word per instruction
  localparam pc_t RESET_PC = 32'd0;

  // --------------------
  // alu control
  // --------------------
  // coarse request from the opcode decoder
  typedef enum logic [1:0] {
    ADD_CLASS,    // lw, sw, addi
    RTYPE_CLASS,  // look at funct
    AND_CLASS,    // andi
    OR_CLASS      // ori
  } aluClass_t;

  // operation actually done by the alu
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL
  } aluOp_t;

endpackage

//--- isaPkg.sv
package isaPkg;

  // --------------------
  // word and field types
  // --------------------
  typedef logic [31:0] word_t;     // one data or instruction word
  typedef logic [4:0]  regAddr_t;  // register index, rs / rt / rd
  typedef logic [5:0]  opcode_t;   // instr[31:26]
  typedef logic [5:0]  funct_t;    // instr[5:0], r-type only
  typedef logic [4:0]  shamt_t;    // instr[10:6]
  typedef logic [15:0] imm_t;      // i-type immediate or offset

  // --------------------
  // sizes
  // --------------------
  localparam int REG_COUNT  = 32;  // architectural registers
  localparam int WORD_BYTES = 4;   // byte address to word index

  // --------------------
  // major opcodes
  // --------------------
  localparam opcode_t OP_RTYPE = 6'b000000;  // alu op picked by funct
  localparam opcode_t OP_LW    = 6'b100011;
  localparam opcode_t OP_SW    = 6'b101011;
  localparam opcode_t OP_ADDI  = 6'b001000;
  localparam opcode_t OP_ANDI  = 6'b001100;  // imm sign-extended here too
  localparam opcode_t OP_ORI   = 6'b001101;  // same

  // --------------------
  // r-type function codes
  // --------------------
  // shifts take rt as source, shamt from the instruction
  localparam funct_t FN_SLL = 6'b000000;
  localparam funct_t FN_SRL = 6'b000010;

  localparam funct_t FN_ADD = 6'b100000;  // no overflow trap
  localparam funct_t FN_SUB = 6'b100010;
  localparam funct_t FN_AND = 6'b100100;
  localparam funct_t FN_OR  = 6'b100101;
  localparam funct_t FN_XOR = 6'b100110;
  localparam funct_t FN_NOR = 6'b100111;
  localparam funct_t FN_SLT = 6'b101010;  // signed compare

endpackage
